// File: hw/burst_adapter.sv
`default_nettype none
`timescale 1ns/10ps
`include "mem_macros.svh"

module burst_adapter (
    input  logic               clk,
    input  logic               arst_n_i,
    input  mem_pkg::line_req_t line_req_i,
    output mem_pkg::line_rsp_t line_rsp_o,
    output logic [31:0]        bmem_address_o,
    output logic               bmem_read_o,
    output logic               bmem_write_o,
    output logic [63:0]        bmem_wdata_o,
    input  logic [63:0]        bmem_rdata_i,
    input  logic               bmem_resp_i
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE,
        ST_DONE
    } state_t;

    localparam int CNT_BITS = $clog2(`BEATS);

    state_t              state_q;
    logic [CNT_BITS-1:0] beat_q;
    cacheline_u          line_q;
    logic                last_beat;

    assign last_beat = bmem_resp_i && (beat_q == CNT_BITS'(`BEATS - 1));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    beat_q <= '0;
                    if (line_req_i.read) begin
                        state_q <= ST_READ;
                    end else if (line_req_i.write) begin
                        state_q <= ST_WRITE;
                    end
                end
                ST_READ, ST_WRITE: begin
                    if (bmem_resp_i) begin
                        beat_q <= beat_q + 1'b1;  // wraps after the last beat
                    end
                    if (last_beat) begin
                        state_q <= ST_DONE;
                    end
                end
                // resp cycle, request still up
                ST_DONE: state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // gather returned beats
    always_ff @(posedge clk) begin
        if ((state_q == ST_READ) && bmem_resp_i) begin
            line_q.beats[beat_q] <= bmem_rdata_i;
        end
    end

    assign bmem_address_o = line_req_i.addr;
    assign bmem_read_o    = (state_q == ST_READ);
    assign bmem_write_o   = (state_q == ST_WRITE);
    assign bmem_wdata_o   = line_req_i.wdata.beats[beat_q];  // beat k until k-th resp

    assign line_rsp_o.resp  = (state_q == ST_DONE);
    assign line_rsp_o.rdata = line_q;

endmodule

`default_nettype wire

// File: hw/cache_arbiter.sv
`default_nettype none
`timescale 1ns/10ps

module cache_arbiter (
    input  logic               clk,
    input  logic               arst_n_i,
    input  mem_pkg::line_req_t icache_req_i,
    output mem_pkg::line_rsp_t icache_rsp_o,
    input  mem_pkg::line_req_t dcache_req_i,
    output mem_pkg::line_rsp_t dcache_rsp_o,
    output mem_pkg::line_req_t mem_req_o,
    input  mem_pkg::line_rsp_t mem_rsp_i
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_ICACHE,
        OWN_DCACHE
    } owner_t;

    owner_t owner_q;
    owner_t sel;

    // idle port goes to the data side first
    always_comb begin
        sel = owner_q;
        if (owner_q == OWN_NONE) begin
            if (dcache_req_i.read || dcache_req_i.write) begin
                sel = OWN_DCACHE;
            end else if (icache_req_i.read || icache_req_i.write) begin
                sel = OWN_ICACHE;
            end
        end
    end

    // grant held until the adapter answers
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            owner_q <= OWN_NONE;
        end else if (mem_rsp_i.resp) begin
            owner_q <= OWN_NONE;
        end else begin
            owner_q <= sel;
        end
    end

    always_comb begin
        case (sel)
            OWN_DCACHE: mem_req_o = dcache_req_i;
            OWN_ICACHE: mem_req_o = icache_req_i;
            default:    mem_req_o = '0;
        endcase
    end

    // line data shared, resp only to the owner
    assign icache_rsp_o.rdata = mem_rsp_i.rdata;
    assign icache_rsp_o.resp  = mem_rsp_i.resp && (owner_q == OWN_ICACHE);
    assign dcache_rsp_o.rdata = mem_rsp_i.rdata;
    assign dcache_rsp_o.resp  = mem_rsp_i.resp && (owner_q == OWN_DCACHE);

endmodule

`default_nettype wire

// File: hw/line_cache.sv
`default_nettype none
`timescale 1ns/10ps
`include "mem_macros.svh"

module line_cache (
    input  logic               clk,
    input  logic               arst_n_i,
    input  mem_pkg::word_req_t req_i,
    output mem_pkg::word_rsp_t rsp_o,
    output mem_pkg::line_req_t line_req_o,
    input  mem_pkg::line_rsp_t line_rsp_i
);
    import mem_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_COMPARE,
        ST_WRITEBACK,
        ST_FILL,
        ST_RESPOND
    } state_t;

    localparam int TAG_BITS = 32 - `IDX_BITS - `OFF_BITS;
    localparam int SEL_BITS = `OFF_BITS - 2;

    state_t              state_q;
    cacheline_u          data_arr [`SETS];
    logic [TAG_BITS-1:0] tag_arr  [`SETS];
    logic [`SETS-1:0]    valid_q;
    logic [`SETS-1:0]    dirty_q;
    word_t               rdata_q;

    line_addr_t          req_addr;
    line_addr_t          victim_addr;
    logic [`IDX_BITS-1:0] idx;
    logic [SEL_BITS-1:0] wsel;
    logic                req_valid;
    logic                hit;
    logic                hit_take;
    logic                fill_take;
    logic                upd;
    cacheline_u          base_line;
    cacheline_u          new_line;

    // byte-masked write into one word of a line
    function automatic cacheline_u merge_word(cacheline_u line, logic [SEL_BITS-1:0] sel,
                                              logic [3:0] mask, word_t data);
        cacheline_u m;
        int         b;
        m = line;
        for (b = 0; b < 4; b++) begin
            if (mask[b]) begin
                m.words[sel][8*b +: 8] = data[8*b +: 8];
            end
        end
        return m;
    endfunction

    assign req_addr  = req_i.addr;
    assign idx       = req_addr.index;
    assign wsel      = req_addr.offset[`OFF_BITS-1:2];
    assign req_valid = req_i.read || req_i.write;
    assign hit       = valid_q[idx] && (tag_arr[idx] == req_addr.tag);

    assign hit_take  = (state_q == ST_IDLE) && req_valid && hit;
    assign fill_take = (state_q == ST_FILL) && line_rsp_i.resp;
    assign upd       = hit_take || fill_take;

    // on a fill the line comes straight off the line port
    assign base_line = (state_q == ST_FILL) ? line_rsp_i.rdata : data_arr[idx];
    assign new_line  = req_i.write ? merge_word(base_line, wsel, req_i.wmask, req_i.wdata)
                                   : base_line;

    assign victim_addr = {tag_arr[idx], idx, {`OFF_BITS{1'b0}}};

    always_comb begin
        line_req_o = '0;
        case (state_q)
            ST_WRITEBACK: begin
                line_req_o.addr  = victim_addr;
                line_req_o.write = 1'b1;
                line_req_o.wdata = data_arr[idx];
            end
            ST_FILL: begin
                line_req_o.addr = {req_addr.tag, idx, {`OFF_BITS{1'b0}}};
                line_req_o.read = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (hit_take) begin
                        state_q <= ST_RESPOND;
                    end else if (req_valid) begin
                        state_q <= ST_COMPARE;
                    end
                end
                ST_COMPARE: begin
                    // dirty victim has to go out first
                    if (valid_q[idx] && dirty_q[idx]) begin
                        state_q <= ST_WRITEBACK;
                    end else begin
                        state_q <= ST_FILL;
                    end
                end
                ST_WRITEBACK: begin
                    if (line_rsp_i.resp) begin
                        state_q <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    if (fill_take) begin
                        state_q <= ST_RESPOND;
                    end
                end
                ST_RESPOND: state_q <= ST_IDLE;  // requester drops meanwhile
                default:    state_q <= ST_IDLE;
            endcase

            if (upd) begin
                valid_q[idx] <= 1'b1;
                dirty_q[idx] <= req_i.write || (hit_take && dirty_q[idx]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (upd) begin
            data_arr[idx] <= new_line;
            tag_arr[idx]  <= req_addr.tag;
            rdata_q       <= new_line.words[wsel];
        end
    end

    assign rsp_o.resp  = (state_q == ST_RESPOND);
    assign rsp_o.rdata = rdata_q;

endmodule

`default_nettype wire

// File: hw/mem_hier_top.sv
`default_nettype none
`timescale 1ns/10ps

module mem_hier_top (
    input  logic               clk,
    input  logic               arst_n_i,
    input  mem_pkg::word_req_t fetch_req_i,
    output mem_pkg::word_rsp_t fetch_rsp_o,
    input  mem_pkg::word_req_t data_req_i,
    output mem_pkg::word_rsp_t data_rsp_o,
    output logic [31:0]        bmem_address_o,
    output logic               bmem_read_o,
    output logic               bmem_write_o,
    output logic [63:0]        bmem_wdata_o,
    input  logic [63:0]        bmem_rdata_i,
    input  logic               bmem_resp_i
);
    import mem_pkg::*;

    line_req_t icache_line_req;
    line_rsp_t icache_line_rsp;
    line_req_t dcache_line_req;
    line_rsp_t dcache_line_rsp;
    line_req_t mem_line_req;    // arbiter to adapter
    line_rsp_t mem_line_rsp;

    line_cache icache0 (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .req_i      (fetch_req_i),
        .rsp_o      (fetch_rsp_o),
        .line_req_o (icache_line_req),
        .line_rsp_i (icache_line_rsp)
    );

    line_cache dcache0 (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .req_i      (data_req_i),
        .rsp_o      (data_rsp_o),
        .line_req_o (dcache_line_req),
        .line_rsp_i (dcache_line_rsp)
    );

    cache_arbiter arbiter0 (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .icache_req_i (icache_line_req),
        .icache_rsp_o (icache_line_rsp),
        .dcache_req_i (dcache_line_req),
        .dcache_rsp_o (dcache_line_rsp),
        .mem_req_o    (mem_line_req),
        .mem_rsp_i    (mem_line_rsp)
    );

    burst_adapter adapter0 (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .line_req_i     (mem_line_req),
        .line_rsp_o     (mem_line_rsp),
        .bmem_address_o (bmem_address_o),
        .bmem_read_o    (bmem_read_o),
        .bmem_write_o   (bmem_write_o),
        .bmem_wdata_o   (bmem_wdata_o),
        .bmem_rdata_i   (bmem_rdata_i),
        .bmem_resp_i    (bmem_resp_i)
    );

endmodule

`default_nettype wire

// File: hw/mem_pkg.sv
`default_nettype none
`include "mem_macros.svh"

package mem_pkg;

    typedef logic [31:0] word_t;

    // byte address as the cache sees it
    typedef struct packed {
        logic [31-`IDX_BITS-`OFF_BITS:0] tag;
        logic [`IDX_BITS-1:0]            index;
        logic [`OFF_BITS-1:0]            offset;  // upper bits pick the word
    } line_addr_t;

    // words for the cache side, beats for the memory side
    typedef union packed {
        word_t [`LINE_BITS/32-1:0]           words;
        logic [`BEATS-1:0][`BEAT_BITS-1:0]   beats;
    } cacheline_u;

    typedef struct packed {
        word_t      addr;
        logic       read;
        logic       write;
        logic [3:0] wmask;
        word_t      wdata;
    } word_req_t;

    typedef struct packed {
        logic  resp;
        word_t rdata;
    } word_rsp_t;

    typedef struct packed {
        word_t      addr;   // line aligned
        logic       read;
        logic       write;
        cacheline_u wdata;
    } line_req_t;

    typedef struct packed {
        logic       resp;
        cacheline_u rdata;
    } line_rsp_t;

endpackage

`default_nettype wire

// File: include/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// line and burst geometry
`define LINE_BITS 256
`define BEAT_BITS 64
`define BEATS     4     // beats per line

// direct-mapped set layout
`define SETS      16
`define IDX_BITS  4
`define OFF_BITS  5     // byte offset in a line

`endif

// File: run.sh
#!/bin/sh
# build and run the memory hierarchy testbench with Verilator
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_mem_hier \
    -o tb_mem_hier > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_mem_hier > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log

grep -q "Done: errors found" sim.log && exit 1
grep -q "Done: no errors" sim.log || exit 1
exit 0

// File: tests/mem_hier_props.sv
`default_nettype none
`timescale 1ns/10ps

module mem_hier_props (
    input wire logic               clk,
    input wire logic               arst_n_i,
    input wire mem_pkg::word_req_t fetch_req_i,
    input wire mem_pkg::word_rsp_t fetch_rsp_o,
    input wire mem_pkg::word_req_t data_req_i,
    input wire mem_pkg::word_rsp_t data_rsp_o,
    input wire mem_pkg::line_req_t mem_line_req_i,
    input wire logic               bmem_read_o,
    input wire logic               bmem_write_o
);
    import mem_pkg::*;

    int fail_count = 0;

    // a resp only answers a live request
    a_fetch_resp_pending: assert property (@(posedge clk) disable iff (!arst_n_i)
        fetch_rsp_o.resp |-> (fetch_req_i.read || fetch_req_i.write))
        else begin
            $error("fetch resp with no pending request");
            fail_count++;
        end
    a_data_resp_pending: assert property (@(posedge clk) disable iff (!arst_n_i)
        data_rsp_o.resp |-> (data_req_i.read || data_req_i.write))
        else begin
            $error("data resp with no pending request");
            fail_count++;
        end

    // burst direction follows the granted line request
    a_bmem_dir: assert property (@(posedge clk) disable iff (!arst_n_i)
        (bmem_read_o || bmem_write_o) |->
            (!(bmem_read_o && bmem_write_o) &&
             (bmem_read_o == mem_line_req_i.read) &&
             (bmem_write_o == mem_line_req_i.write)))
        else begin
            $error("burst read and write do not match one granted line request");
            fail_count++;
        end

    // requester holds its fields until resp
    a_fetch_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        ((fetch_req_i.read || fetch_req_i.write) && !fetch_rsp_o.resp) |=> $stable(fetch_req_i))
        else begin
            $error("fetch request changed before resp");
            fail_count++;
        end
    a_data_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        ((data_req_i.read || data_req_i.write) && !data_rsp_o.resp) |=> $stable(data_req_i))
        else begin
            $error("data request changed before resp");
            fail_count++;
        end

    a_reset_strobes: assert property (@(posedge clk)
        $rose(arst_n_i) |-> (!bmem_read_o && !bmem_write_o))
        else begin
            $error("burst strobes high right after reset");
            fail_count++;
        end

endmodule

bind mem_hier_top mem_hier_props props0 (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .fetch_req_i    (fetch_req_i),
    .fetch_rsp_o    (fetch_rsp_o),
    .data_req_i     (data_req_i),
    .data_rsp_o     (data_rsp_o),
    .mem_line_req_i (mem_line_req),
    .bmem_read_o    (bmem_read_o),
    .bmem_write_o   (bmem_write_o)
);

`default_nettype wire

// File: tests/tb_mem_hier.sv
`default_nettype none
`timescale 1ns/10ps

module tb_mem_hier;
    import mem_pkg::*;

    localparam int REQ_COUNT   = 323;                // all requests over all tests
    localparam int CYCLE_LIMIT = 40 * REQ_COUNT * 20;

    logic        clk;
    logic        arst_n;
    word_req_t   fetch_req;
    word_rsp_t   fetch_rsp;
    word_req_t   data_req;
    word_rsp_t   data_rsp;
    logic [31:0] bmem_address;
    logic        bmem_read;
    logic        bmem_write;
    logic [63:0] bmem_wdata;
    logic [63:0] bmem_rdata;
    logic        bmem_resp;

    logic [31:0] lfsr = 32'h3d5080af;
    logic [7:0]  mem   [8192];   // burst memory contents
    logic [7:0]  model [8192];   // expected byte view
    int          errors = 0;
    int          issued = 0;
    int          cycle = 0;

    mem_hier_top uut (
        .clk            (clk),
        .arst_n_i       (arst_n),
        .fetch_req_i    (fetch_req),
        .fetch_rsp_o    (fetch_rsp),
        .data_req_i     (data_req),
        .data_rsp_o     (data_rsp),
        .bmem_address_o (bmem_address),
        .bmem_read_o    (bmem_read),
        .bmem_write_o   (bmem_write),
        .bmem_wdata_o   (bmem_wdata),
        .bmem_rdata_i   (bmem_rdata),
        .bmem_resp_i    (bmem_resp)
    );

    // one galois step per bit taken
    function automatic logic [31:0] rnd(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t model_word(input word_t addr);
        return {model[addr[12:0] + 3], model[addr[12:0] + 2],
                model[addr[12:0] + 1], model[addr[12:0]]};
    endfunction

    function automatic word_t mem_word(input word_t addr);
        return {mem[addr[12:0] + 3], mem[addr[12:0] + 2], mem[addr[12:0] + 1], mem[addr[12:0]]};
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report(input string name, input int errs_before);
        $display("test %s: %s", name, (errors == errs_before) ? "pass" : "fail");
    endtask

    // one word request, held until resp, latency in cycles
    task automatic access(input bit port, input word_t addr, input bit wr, input logic [3:0] mask,
                          input word_t wdata, output word_t rdata, output int cycles);
        word_req_t r;
        bit        done;
        r.addr  = addr;
        r.read  = !wr;
        r.write = wr;
        r.wmask = wr ? mask : 4'h0;
        r.wdata = wdata;
        cycles  = 0;
        done    = 0;
        @(posedge clk);
        #2;
        if (port) data_req = r;
        else fetch_req = r;
        issued++;
        if (wr) begin
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) model[addr[12:0] + b] = wdata[8*b +: 8];
            end
        end
        while (!done) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            done = port ? data_rsp.resp : fetch_rsp.resp;
        end
        rdata = port ? data_rsp.rdata : fetch_rsp.rdata;
        @(posedge clk);
        #2;
        if (port) data_req = '0;
        else fetch_req = '0;
    endtask

    task automatic read_check(input bit port, input word_t addr, input string name);
        word_t got;
        word_t exp;
        int    cyc;
        exp = model_word(addr);
        access(port, addr, 1'b0, 4'h0, '0, got, cyc);
        check(name, got, exp);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // behavioral burst memory, 0 to 3 idle cycles per beat
    initial begin
        int beat;
        int delay;
        bit armed;
        bmem_rdata = '0;
        bmem_resp  = 1'b0;
        beat  = 0;
        armed = 0;
        delay = 0;
        forever begin
            @(posedge clk);
            #2;
            bmem_resp = 1'b0;
            if (!(bmem_read || bmem_write)) begin
                beat  = 0;
                armed = 0;
            end else begin
                if (!armed) begin
                    delay = int'(rnd(2));
                    armed = 1;
                end
                if (delay == 0) begin
                    for (int j = 0; j < 8; j++) begin
                        if (bmem_write) begin
                            mem[bmem_address[12:0] + 8*beat + j] = bmem_wdata[8*j +: 8];
                        end else begin
                            bmem_rdata[8*j +: 8] = mem[bmem_address[12:0] + 8*beat + j];
                        end
                    end
                    bmem_resp = 1'b1;
                    beat++;
                    armed = 0;
                end else begin
                    delay--;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        word_t got;
        word_t wd;
        int    cyc;
        int    e0;
        logic [3:0] mask;
        fetch_req  = '0;
        data_req   = '0;
        arst_n     = 1'b0;
        for (int a = 0; a < 8192; a++) begin
            mem[a]   = 8'(a ^ (a >> 5) ^ ((a >> 8) * 37));
            model[a] = mem[a];
        end
        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;

        e0 = errors;
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            check("fetch_rsp_o.resp", fetch_rsp.resp, 1'b0);
            check("data_rsp_o.resp", data_rsp.resp, 1'b0);
            check("bmem_read_o", bmem_read, 1'b0);
            check("bmem_write_o", bmem_write, 1'b0);
        end
        report("reset", e0);

        e0 = errors;
        read_check(1'b0, 32'h0000_0044, "fetch_rsp_o.rdata");    // miss
        access(1'b0, 32'h0000_0044, 1'b0, 4'h0, '0, got, cyc);   // hit
        check("fetch_rsp_o.rdata", got, model_word(32'h0000_0044));
        check("hit latency", cyc, 1);
        report("fetch read", e0);

        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            mask = 4'(rnd(4));
            wd   = rnd(32);
            access(1'b1, 32'h1100 + 4 * i, 1'b1, mask, wd, got, cyc);
        end
        for (int i = 0; i < 8; i++) read_check(1'b1, 32'h1100 + 4 * i, "data_rsp_o.rdata");
        report("data write merge", e0);

        e0 = errors;
        access(1'b1, 32'h1008, 1'b1, 4'hf, 32'hcafe_f00d, got, cyc);
        read_check(1'b1, 32'h1208, "data_rsp_o.rdata");          // same index, evicts
        check("bmem array word", mem_word(32'h1008), model_word(32'h1008));
        read_check(1'b1, 32'h1008, "data_rsp_o.rdata");
        report("dirty eviction", e0);

        e0 = errors;
        fork
            read_check(1'b0, 32'h0000_0820, "fetch_rsp_o.rdata");
            read_check(1'b1, 32'h0000_1460, "data_rsp_o.rdata");
        join
        report("concurrent miss", e0);

        e0 = errors;
        fork
            begin
                repeat (100) begin
                    read_check(1'b0, {20'h0, 10'(rnd(10)), 2'b00}, "fetch_rsp_o.rdata");
                end
            end
            begin
                word_t a;
                repeat (200) begin
                    a = 32'h1000 | {20'h0, 10'(rnd(10)), 2'b00};
                    if (rnd(1) != '0) access(1'b1, a, 1'b1, 4'(rnd(4)), rnd(32), got, cyc);
                    else read_check(1'b1, a, "data_rsp_o.rdata");
                end
            end
        join
        report("random mix", e0);

        errors += uut.props0.fail_count;
        $display("requests %0d, cycles %0d, errors %0d", issued, cycle, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
hw/mem_pkg.sv
hw/line_cache.sv
hw/cache_arbiter.sv
hw/burst_adapter.sv
hw/mem_hier_top.sv
tests/mem_hier_props.sv
tests/tb_mem_hier.sv
